// File: source/cp0_pkg.sv
package cp0_pkg;

    localparam int DATA_W   = 32;
    localparam int ADDR_W   = 8;                 // Register number and select
    localparam int HW_INT_W = 6;

    // Addresses are {rd, sel}
    localparam logic [ADDR_W-1:0] BADVADDR_ADDR = 8'h40;   // rd 8
    localparam logic [ADDR_W-1:0] COUNT_ADDR    = 8'h48;   // rd 9
    localparam logic [ADDR_W-1:0] COMPARE_ADDR  = 8'h58;   // rd 11
    localparam logic [ADDR_W-1:0] STATUS_ADDR   = 8'h60;   // rd 12
    localparam logic [ADDR_W-1:0] CAUSE_ADDR    = 8'h68;   // rd 13
    localparam logic [ADDR_W-1:0] EPC_ADDR      = 8'h70;   // rd 14

    localparam logic [DATA_W-1:0] COMPARE_RESET = 32'h0001_55cc;

    // Exception causes as reported by the memory stage
    typedef enum logic [4:0] {
        Int   = 5'h00,
        AdEL  = 5'h01,
        AdES  = 5'h02,
        Sys   = 5'h03,
        Bp    = 5'h04,
        RI    = 5'h05,
        CpU   = 5'h06,
        Ov    = 5'h07,
        Trap  = 5'h08,
        NO_EX = 5'h1f
    } exc_type_e;

    typedef logic [4:0] exc_code_t;                // Architectural ExcCode

    localparam exc_code_t EXC_INT  = 5'h00;
    localparam exc_code_t EXC_ADEL = 5'h04;
    localparam exc_code_t EXC_ADES = 5'h05;
    localparam exc_code_t EXC_SYS  = 5'h08;
    localparam exc_code_t EXC_BP   = 5'h09;
    localparam exc_code_t EXC_RI   = 5'h0a;
    localparam exc_code_t EXC_CPU  = 5'h0b;
    localparam exc_code_t EXC_OV   = 5'h0c;
    localparam exc_code_t EXC_TR   = 5'h0d;

    typedef struct packed {
        logic              valid;
        logic              is_mtc0;
        logic              is_eret;
        logic              ex;                   // Exception raised in this stage
        logic              bd;                   // Instruction in a delay slot
        exc_type_e         exc_type;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;                // Move-to data or faulting address
        logic [DATA_W-1:0] pc;
    } cp0_req_t;

    typedef struct packed {
        logic status;
        logic cause;
        logic epc;
        logic badvaddr;
        logic count;
        logic compare;
    } cp0_wstrobe_t;

    typedef struct packed {
        logic [2:0] zero_31_29;
        logic       cu0;
        logic [4:0] zero_27_23;
        logic       bev;
        logic [5:0] zero_21_16;
        logic [7:0] im;
        logic [2:0] zero_7_5;
        logic       um;
        logic       zero_3;
        logic       erl;
        logic       exl;
        logic       ie;
    } status_bits_t;

    typedef struct packed {
        logic        bd;
        logic        ti;
        logic [1:0]  ce;
        logic [11:0] zero_27_16;
        logic [7:0]  ip;
        logic        zero_7;
        exc_code_t   exc_code;
        logic [1:0]  zero_1_0;
    } cause_bits_t;

    // One bus word, read as Status or Cause by address
    typedef union packed {
        logic [DATA_W-1:0] raw;
        status_bits_t      status;
        cause_bits_t       cause;
    } cp0_word_u;

    typedef struct packed {
        logic       ie;
        logic       exl;
        logic [7:0] im;
        logic [7:0] ip;
        logic       ti;
    } cp0_irq_t;

endpackage

// File: source/cp0_access_port.sv
module cp0_access_port (
    input  cp0_pkg::cp0_req_t                req,
    input  cp0_pkg::status_bits_t            status,
    input  cp0_pkg::cause_bits_t             cause,
    input  logic [cp0_pkg::DATA_W-1:0]       epc,
    input  logic [cp0_pkg::DATA_W-1:0]       badvaddr,
    input  logic [cp0_pkg::DATA_W-1:0]       count,
    input  logic [cp0_pkg::DATA_W-1:0]       compare,
    output cp0_pkg::cp0_wstrobe_t            wstrobe,
    output logic                             eret_commit,
    output logic                             eret_flush,
    output logic [cp0_pkg::DATA_W-1:0]       rdata
);

    logic               mtc0_we;
    logic               eret_go;
    cp0_pkg::cp0_word_u rd_word;

    // A faulting instruction neither writes nor returns
    assign mtc0_we = req.valid && req.is_mtc0 && !req.ex;
    assign eret_go = req.valid && req.is_eret && !req.ex;

    assign eret_commit = eret_go;
    assign eret_flush  = eret_go;                // Pipeline flush in the same cycle

    always_comb begin
        wstrobe = '0;
        if (mtc0_we) begin
            case (req.addr)
                cp0_pkg::STATUS_ADDR:   wstrobe.status   = 1'b1;
                cp0_pkg::CAUSE_ADDR:    wstrobe.cause    = 1'b1;
                cp0_pkg::EPC_ADDR:      wstrobe.epc      = 1'b1;
                cp0_pkg::BADVADDR_ADDR: wstrobe.badvaddr = 1'b1;
                cp0_pkg::COUNT_ADDR:    wstrobe.count    = 1'b1;
                cp0_pkg::COMPARE_ADDR:  wstrobe.compare  = 1'b1;
                default:                wstrobe          = '0;
            endcase
        end
    end

    // Move-from data, combinational on the request address
    always_comb begin
        rd_word.raw = '0;                        // Dropped addresses read zero
        case (req.addr)
            cp0_pkg::STATUS_ADDR: begin
                rd_word.status.cu0 = status.cu0;
                rd_word.status.bev = status.bev;
                rd_word.status.im  = status.im;
                rd_word.status.um  = status.um;
                rd_word.status.erl = status.erl;
                rd_word.status.exl = status.exl;
                rd_word.status.ie  = status.ie;
            end
            cp0_pkg::CAUSE_ADDR: begin
                rd_word.cause.bd       = cause.bd;
                rd_word.cause.ti       = cause.ti;
                rd_word.cause.ce       = cause.ce;
                rd_word.cause.ip       = cause.ip;
                rd_word.cause.exc_code = cause.exc_code;
            end
            cp0_pkg::EPC_ADDR:      rd_word.raw = epc;
            cp0_pkg::BADVADDR_ADDR: rd_word.raw = badvaddr;
            cp0_pkg::COUNT_ADDR:    rd_word.raw = count;
            cp0_pkg::COMPARE_ADDR:  rd_word.raw = compare;
            default:                rd_word.raw = '0;
        endcase
    end

    assign rdata = rd_word.raw;

endmodule

// File: source/cp0_status_reg.sv
module cp0_status_reg (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wstrobe_status,
    input  cp0_pkg::cp0_word_u    wdata,
    input  logic                  ex,
    input  logic                  eret_commit,
    output cp0_pkg::status_bits_t status
);

    cp0_pkg::status_bits_t status_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            status_q     <= '0;                  // Reserved bits stay zero from here on
            status_q.bev <= 1'b1;                // Boot vectors after reset
        end else begin
            if (wstrobe_status) begin
                status_q.cu0 <= wdata.status.cu0;
                status_q.bev <= wdata.status.bev;
                status_q.im  <= wdata.status.im;
                status_q.um  <= wdata.status.um;
                status_q.erl <= wdata.status.erl;
                status_q.ie  <= wdata.status.ie;
            end

            // Exception entry wins over return, return over move-to
            if (ex) begin
                status_q.exl <= 1'b1;
            end else if (eret_commit) begin
                status_q.exl <= 1'b0;
            end else if (wstrobe_status) begin
                status_q.exl <= wdata.status.exl;
            end
        end
    end

    assign status = status_q;

endmodule

// File: source/cp0_exception_unit.sv
module cp0_exception_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  cp0_pkg::cp0_req_t             req,
    input  logic                          wstrobe_epc,
    input  logic                          exl,
    output logic [cp0_pkg::DATA_W-1:0]    epc,
    output logic [cp0_pkg::DATA_W-1:0]    badvaddr,
    output logic                          bd,
    output cp0_pkg::exc_code_t            exc_code,
    output logic [1:0]                    ce
);

    logic                       first_ex;
    cp0_pkg::exc_code_t         code_next;
    logic [cp0_pkg::DATA_W-1:0] epc_next;

    // Nested exceptions keep the original return point
    assign first_ex = req.ex && !exl;

    // Delay slot faults return to the branch
    assign epc_next = req.bd ? req.pc - 32'd4 : req.pc;

    always_comb begin
        case (req.exc_type)
            cp0_pkg::Int:  code_next = cp0_pkg::EXC_INT;
            cp0_pkg::AdEL: code_next = cp0_pkg::EXC_ADEL;
            cp0_pkg::AdES: code_next = cp0_pkg::EXC_ADES;
            cp0_pkg::Sys:  code_next = cp0_pkg::EXC_SYS;
            cp0_pkg::Bp:   code_next = cp0_pkg::EXC_BP;
            cp0_pkg::RI:   code_next = cp0_pkg::EXC_RI;
            cp0_pkg::CpU:  code_next = cp0_pkg::EXC_CPU;
            cp0_pkg::Ov:   code_next = cp0_pkg::EXC_OV;
            cp0_pkg::Trap: code_next = cp0_pkg::EXC_TR;
            default:       code_next = '0;      // NO_EX and unknown causes
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            epc <= '0;
            bd  <= 1'b0;
        end else if (first_ex) begin
            epc <= epc_next;
            bd  <= req.bd;
        end else if (wstrobe_epc) begin
            epc <= req.wdata;                    // Strobe already excludes faulting requests
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exc_code <= '0;
            ce       <= 2'b00;
        end else if (req.ex) begin
            exc_code <= code_next;
            if (req.exc_type == cp0_pkg::CpU) begin
                ce <= 2'b01;                     // Only CP1 is ever reported unusable
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            badvaddr <= '0;
        end else if (req.ex) begin
            if (req.exc_type == cp0_pkg::AdES) begin
                badvaddr <= req.wdata;
            end else if (req.exc_type == cp0_pkg::AdEL) begin
                badvaddr <= (req.pc[1:0] != 2'b00) ? req.pc : req.wdata; // Fetch or load
            end
        end
    end

endmodule

// File: source/cp0_interrupt_unit.sv
module cp0_interrupt_unit (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            wstrobe_count,
    input  logic                            wstrobe_compare,
    input  logic                            wstrobe_cause,
    input  cp0_pkg::cp0_word_u              wdata,
    input  logic [cp0_pkg::HW_INT_W-1:0]    ext_int,
    output logic [cp0_pkg::DATA_W-1:0]      count,
    output logic [cp0_pkg::DATA_W-1:0]      compare,
    output logic                            ti,
    output logic [7:0]                      ip
);

    logic tick;                                  // Half-rate enable for Count
    logic count_hit;

    assign count_hit = (count == compare);

    always_ff @(posedge clk) begin
        if (reset) begin
            tick <= 1'b0;
        end else begin
            tick <= ~tick;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (wstrobe_count) begin
            count <= wdata.raw;                  // Software load beats the increment
        end else if (tick) begin
            count <= count + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare <= cp0_pkg::COMPARE_RESET;
        end else if (wstrobe_compare) begin
            compare <= wdata.raw;
        end
    end

    // Writing Compare acknowledges the timer interrupt
    always_ff @(posedge clk) begin
        if (reset) begin
            ti <= 1'b0;
        end else if (wstrobe_compare) begin
            ti <= 1'b0;
        end else if (count_hit) begin
            ti <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ip <= '0;
        end else begin
            ip[7]   <= ext_int[cp0_pkg::HW_INT_W-1] | ti; // Timer shares the top line
            ip[6:2] <= ext_int[cp0_pkg::HW_INT_W-2:0];
            if (wstrobe_cause) begin
                ip[1:0] <= wdata.cause.ip[1:0];  // Software interrupts
            end
        end
    end

endmodule

// File: source/cp0_top.sv
module cp0_top (
    input  logic                          clk,
    input  logic                          reset,
    input  cp0_pkg::cp0_req_t             req,
    input  logic [cp0_pkg::HW_INT_W-1:0]  ext_int,
    output logic [cp0_pkg::DATA_W-1:0]    rdata,
    output logic                          eret_flush,
    output logic [cp0_pkg::DATA_W-1:0]    epc,
    output cp0_pkg::cp0_irq_t             irq
);

    cp0_pkg::cp0_wstrobe_t      wstrobe;
    cp0_pkg::cp0_word_u         wdata_word;
    cp0_pkg::status_bits_t      status;
    cp0_pkg::cause_bits_t       cause;
    cp0_pkg::exc_code_t         exc_code;
    logic                       eret_commit;
    logic                       bd;
    logic                       ti;
    logic [1:0]                 ce;
    logic [7:0]                 ip;
    logic [cp0_pkg::DATA_W-1:0] badvaddr;
    logic [cp0_pkg::DATA_W-1:0] count;
    logic [cp0_pkg::DATA_W-1:0] compare;

    assign wdata_word.raw = req.wdata;

    // Cause fields come from two blocks
    assign cause = '{bd: bd, ti: ti, ce: ce, zero_27_16: 12'h000, ip: ip,
                     zero_7: 1'b0, exc_code: exc_code, zero_1_0: 2'b00};

    assign irq = '{ie: status.ie, exl: status.exl, im: status.im, ip: ip, ti: ti};

    cp0_access_port u_access_port (
        .req         (req),
        .status      (status),
        .cause       (cause),
        .epc         (epc),
        .badvaddr    (badvaddr),
        .count       (count),
        .compare     (compare),
        .wstrobe     (wstrobe),
        .eret_commit (eret_commit),
        .eret_flush  (eret_flush),
        .rdata       (rdata)
    );

    cp0_status_reg u_status_reg (
        .clk            (clk),
        .reset          (reset),
        .wstrobe_status (wstrobe.status),
        .wdata          (wdata_word),
        .ex             (req.ex),
        .eret_commit    (eret_commit),
        .status         (status)
    );

    cp0_exception_unit u_exception_unit (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .wstrobe_epc (wstrobe.epc),
        .exl         (status.exl),
        .epc         (epc),
        .badvaddr    (badvaddr),
        .bd          (bd),
        .exc_code    (exc_code),
        .ce          (ce)
    );

    cp0_interrupt_unit u_interrupt_unit (
        .clk             (clk),
        .reset           (reset),
        .wstrobe_count   (wstrobe.count),
        .wstrobe_compare (wstrobe.compare),
        .wstrobe_cause   (wstrobe.cause),
        .wdata           (wdata_word),
        .ext_int         (ext_int),
        .count           (count),
        .compare         (compare),
        .ti              (ti),
        .ip              (ip)
    );

endmodule

// File: dv/cp0_clock_gen.sv
module cp0_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 4,
    parameter int DRIVE_DELAY  = 1
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY) reset = 1'b0;             // Released off the edge like other inputs
    end

endmodule

// File: dv/cp0_assertions.sv
module cp0_assertions (
    input logic              clk,
    input logic              reset,
    input cp0_pkg::cp0_req_t req,
    input logic              eret_flush,
    input cp0_pkg::cp0_irq_t irq
);

    logic compare_write;
    int   fail_count;                            // Failed assertions so far

    initial fail_count = 0;

    assign compare_write = req.valid && req.is_mtc0 && !req.ex
                           && (req.addr == cp0_pkg::COMPARE_ADDR);

    flush_from_clean_request: assert property (@(posedge clk) disable iff (reset)
        eret_flush |-> (req.valid && !req.ex) ##1 !irq.exl)
        else begin
            fail_count++;
            $error("ERET flush from an invalid or faulting request, or EXL still set after it");
        end

    exl_after_exception: assert property (@(posedge clk) disable iff (reset)
        req.ex |=> irq.exl)
        else begin
            fail_count++;
            $error("EXL not set one cycle after an exception");
        end

    ti_cleared_by_compare: assert property (@(posedge clk) disable iff (reset)
        compare_write |=> !irq.ti)
        else begin
            fail_count++;
            $error("Timer interrupt still set after a Compare write");
        end

endmodule

bind cp0_top cp0_assertions u_assertions (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .eret_flush (eret_flush),
    .irq        (irq)
);

// File: dv/cp0_tb.sv
module cp0_tb;

    localparam int PERIOD       = 8;
    localparam int RESET_CYCLES = 4;
    localparam int DRV          = 1;             // Input drive delay after the edge
    localparam int TI_LEAD      = 3;             // Compare distance ahead of Count
    localparam int TEST_CYCLES  = 20 + 140 + 260 + 110 + 60;  // Budgets in test order
    localparam int MARGIN       = 100;
    localparam logic [31:0] LFSR_SEED    = 32'h3d92;
    localparam logic [31:0] STATUS_WMASK = 32'h1040_ff17;   // CU0 BEV IM UM ERL EXL IE

    logic                         clk;
    logic                         reset;
    cp0_pkg::cp0_req_t            req;
    logic [cp0_pkg::HW_INT_W-1:0] ext_int;
    logic [cp0_pkg::DATA_W-1:0]   rdata;
    logic                         eret_flush;
    logic [cp0_pkg::DATA_W-1:0]   epc;
    cp0_pkg::cp0_irq_t            irq;

    cp0_pkg::status_bits_t        m_status;      // Reference register state
    cp0_pkg::cause_bits_t         m_cause;
    logic [31:0]                  m_epc;
    logic [31:0]                  m_badvaddr;
    logic [31:0]                  m_compare;
    logic [5:0]                   m_ext;

    logic [31:0]                  lfsr_state;
    string                        test_name;
    logic                         word_pending;
    logic                         irq_pending;
    logic                         flag_pending;
    logic                         epc_pending;
    string                        word_label;
    string                        irq_label;
    string                        flag_label;
    string                        epc_label;
    logic [31:0]                  word_lo;
    logic [31:0]                  word_hi;
    cp0_pkg::cp0_irq_t            irq_exp;
    logic                         flag_exp;
    logic [31:0]                  epc_exp;

    cp0_clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYCLES), .DRIVE_DELAY(DRV))
        u_clock_gen (.clk(clk), .reset(reset));

    cp0_top uut (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .ext_int    (ext_int),
        .rdata      (rdata),
        .eret_flush (eret_flush),
        .epc        (epc),
        .irq        (irq)
    );

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic cp0_pkg::cp0_req_t idle_req();
        cp0_pkg::cp0_req_t r;
        r = '0;
        r.exc_type = cp0_pkg::NO_EX;
        return r;
    endfunction

    function automatic cp0_pkg::exc_code_t exp_exc_code(cp0_pkg::exc_type_e t);
        case (t)
            cp0_pkg::Int:  return cp0_pkg::EXC_INT;
            cp0_pkg::AdEL: return cp0_pkg::EXC_ADEL;
            cp0_pkg::AdES: return cp0_pkg::EXC_ADES;
            cp0_pkg::Sys:  return cp0_pkg::EXC_SYS;
            cp0_pkg::Bp:   return cp0_pkg::EXC_BP;
            cp0_pkg::RI:   return cp0_pkg::EXC_RI;
            cp0_pkg::CpU:  return cp0_pkg::EXC_CPU;
            cp0_pkg::Ov:   return cp0_pkg::EXC_OV;
            cp0_pkg::Trap: return cp0_pkg::EXC_TR;
            default:       return '0;
        endcase
    endfunction

    // Cause with the sampled hardware lines folded in
    function automatic cp0_pkg::cause_bits_t cause_now();
        cp0_pkg::cause_bits_t c;
        c = m_cause;
        c.ip[7] = m_ext[5] | m_cause.ti;
        c.ip[6:2] = m_ext[4:0];
        return c;
    endfunction

    function automatic cp0_pkg::cp0_irq_t model_irq();
        cp0_pkg::cause_bits_t c;
        c = cause_now();
        return '{ie: m_status.ie, exl: m_status.exl, im: m_status.im, ip: c.ip, ti: c.ti};
    endfunction

    // Expected move-from word for an address
    function automatic logic [31:0] ref_read(logic [cp0_pkg::ADDR_W-1:0] addr);
        case (addr)
            cp0_pkg::STATUS_ADDR:   return m_status;
            cp0_pkg::CAUSE_ADDR:    return cause_now();
            cp0_pkg::EPC_ADDR:      return m_epc;
            cp0_pkg::BADVADDR_ADDR: return m_badvaddr;
            cp0_pkg::COMPARE_ADDR:  return m_compare;
            default:                return '0;
        endcase
    endfunction

    function automatic void apply_write(logic [cp0_pkg::ADDR_W-1:0] addr, logic [31:0] d);
        case (addr)
            cp0_pkg::STATUS_ADDR: m_status = d & STATUS_WMASK;
            cp0_pkg::CAUSE_ADDR:  m_cause.ip[1:0] = d[9:8];
            cp0_pkg::EPC_ADDR:    m_epc = d;
            cp0_pkg::COMPARE_ADDR: begin
                m_compare = d;
                m_cause.ti = 1'b0;
            end
            default: ;
        endcase
    endfunction

    function automatic void apply_exception(cp0_pkg::cp0_req_t r);
        if (!m_status.exl) begin
            m_epc = r.bd ? r.pc - 32'd4 : r.pc;
            m_cause.bd = r.bd;
        end
        m_status.exl = 1'b1;
        m_cause.exc_code = exp_exc_code(r.exc_type);
        if (r.exc_type == cp0_pkg::CpU) begin
            m_cause.ce = 2'b01;
        end
        if (r.exc_type == cp0_pkg::AdES) begin
            m_badvaddr = r.wdata;
        end else if (r.exc_type == cp0_pkg::AdEL) begin
            m_badvaddr = (r.pc[1:0] != 2'b00) ? r.pc : r.wdata;
        end
    endfunction

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(string label, logic [cp0_pkg::DATA_W-1:0] lo,
                              logic [cp0_pkg::DATA_W-1:0] hi, logic [cp0_pkg::DATA_W-1:0] act);
        if ($isunknown(act) || act < lo || act > hi) begin
            if (lo == hi) begin
                abort_run($sformatf("FAILED %s/%s expected %h actual %h",
                                    test_name, label, lo, act));
            end else begin
                abort_run($sformatf("FAILED %s/%s expected %h..%h actual %h",
                                    test_name, label, lo, hi, act));
            end
        end
    endtask

    task automatic check_irq(string label, cp0_pkg::cp0_irq_t exp, cp0_pkg::cp0_irq_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAILED %s/%s expected %h actual %h", test_name, label, exp, act));
        end
    endtask

    task automatic check_flag(string label, logic exp, logic act);
        if (act !== exp) begin
            abort_run($sformatf("FAILED %s/%s expected %b actual %b", test_name, label, exp, act));
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (uut.u_assertions.fail_count != 0) begin
            abort_run("A bound assertion failed during the run");
        end
        if (word_pending) begin
            word_pending = 1'b0;
            check_word(word_label, word_lo, word_hi, rdata);
        end
        if (irq_pending) begin
            irq_pending = 1'b0;
            check_irq(irq_label, irq_exp, irq);
        end
        if (flag_pending) begin
            flag_pending = 1'b0;
            check_flag(flag_label, flag_exp, eret_flush);
        end
        if (epc_pending) begin
            epc_pending = 1'b0;
            check_word(epc_label, epc_exp, epc_exp, epc);
        end
    end

    initial begin
        #((TEST_CYCLES + MARGIN + RESET_CYCLES) * PERIOD);
        abort_run($sformatf("Watchdog expired after %0d cycles without the tests finishing",
                            TEST_CYCLES + MARGIN + RESET_CYCLES));
    end

    task automatic wait_cycles(int n);
        repeat (n) begin
            @(posedge clk);
            #DRV;
        end
    endtask

    // One request for one cycle, then back to idle
    task automatic issue(cp0_pkg::cp0_req_t r);
        req = r;
        @(posedge clk);
        #DRV;
        req = idle_req();
    endtask

    task automatic write_reg(logic [cp0_pkg::ADDR_W-1:0] addr, logic [31:0] d);
        cp0_pkg::cp0_req_t r;
        r = idle_req();
        r.valid = 1'b1;
        r.is_mtc0 = 1'b1;
        r.addr = addr;
        r.wdata = d;
        apply_write(addr, d);
        issue(r);
    endtask

    task automatic read_range(string label, logic [cp0_pkg::ADDR_W-1:0] addr,
                              logic [31:0] lo, logic [31:0] hi);
        cp0_pkg::cp0_req_t r;
        r = idle_req();
        r.valid = 1'b1;
        r.addr = addr;
        word_label = label;
        word_lo = lo;
        word_hi = hi;
        word_pending = 1'b1;
        issue(r);
    endtask

    task automatic read_reg(string label, logic [cp0_pkg::ADDR_W-1:0] addr);
        read_range(label, addr, ref_read(addr), ref_read(addr));
    endtask

    task automatic expect_irq(string label);
        irq_label = label;
        irq_exp = model_irq();
        irq_pending = 1'b1;
    endtask

    // EPC output port against the model
    task automatic expect_epc(string label);
        epc_label = label;
        epc_exp = m_epc;
        epc_pending = 1'b1;
    endtask

    task automatic do_eret();
        cp0_pkg::cp0_req_t r;
        r = idle_req();
        r.valid = 1'b1;
        r.is_eret = 1'b1;
        flag_label = "eret_flush";
        flag_exp = 1'b1;
        flag_pending = 1'b1;
        m_status.exl = 1'b0;
        issue(r);
    endtask

    task automatic set_ext_int(logic [5:0] v);
        ext_int = v;
        m_ext = v;
        wait_cycles(1);
    endtask

    task automatic reset_values_test();
        test_name = "reset";
        read_range("count", cp0_pkg::COUNT_ADDR, 32'd0, 32'd0);
        read_reg("status", cp0_pkg::STATUS_ADDR);
        read_reg("cause", cp0_pkg::CAUSE_ADDR);
        read_reg("epc", cp0_pkg::EPC_ADDR);
        read_reg("badvaddr", cp0_pkg::BADVADDR_ADDR);
        read_reg("compare", cp0_pkg::COMPARE_ADDR);
        expect_irq("irq");
        read_reg("index", 8'h00);
        read_reg("entryhi", 8'h50);
        read_reg("unknown", 8'hff);
    endtask

    task automatic move_access_test();
        cp0_pkg::cp0_req_t r;
        test_name = "move_access";
        for (int i = 0; i < 12; i++) begin
            write_reg(cp0_pkg::STATUS_ADDR, take_bits(32));
            read_reg("status", cp0_pkg::STATUS_ADDR);
            expect_irq("irq");
            write_reg(cp0_pkg::EPC_ADDR, take_bits(32));
            expect_epc("epc_port");
            read_reg("epc", cp0_pkg::EPC_ADDR);
            write_reg(cp0_pkg::COMPARE_ADDR, take_bits(32));
            read_reg("compare", cp0_pkg::COMPARE_ADDR);
            write_reg(cp0_pkg::CAUSE_ADDR, take_bits(32));
            read_reg("cause", cp0_pkg::CAUSE_ADDR);
        end
        write_reg(cp0_pkg::STATUS_ADDR, 32'h0040_0000);
        r = idle_req();                          // Faulting move-to must not write
        r.valid = 1'b1;
        r.is_mtc0 = 1'b1;
        r.ex = 1'b1;
        r.exc_type = cp0_pkg::Ov;
        r.addr = cp0_pkg::COMPARE_ADDR;
        r.wdata = ~m_compare;
        r.pc = {take_bits(30), 2'b00};
        apply_exception(r);
        issue(r);
        read_reg("compare_ex", cp0_pkg::COMPARE_ADDR);
        r.addr = cp0_pkg::CAUSE_ADDR;
        r.wdata = 32'hffff_ffff ^ {22'd0, m_cause.ip[1:0], 8'd0};
        apply_exception(r);
        issue(r);
        read_reg("cause_ex", cp0_pkg::CAUSE_ADDR);
        do_eret();
        read_reg("status_ex", cp0_pkg::STATUS_ADDR);
    endtask

    task automatic exception_entry_test();
        cp0_pkg::exc_type_e types [9];
        cp0_pkg::cp0_req_t  r;
        test_name = "exception";
        types = '{cp0_pkg::Int, cp0_pkg::AdEL, cp0_pkg::AdES, cp0_pkg::Sys, cp0_pkg::Bp,
                  cp0_pkg::RI, cp0_pkg::CpU, cp0_pkg::Ov, cp0_pkg::Trap};
        for (int i = 0; i < 9; i++) begin
            for (int n = 0; n < 2; n++) begin
                r = idle_req();
                r.valid = 1'b1;
                r.ex = 1'b1;
                r.exc_type = types[i];
                r.bd = 1'(take_bits(1));
                r.wdata = take_bits(32);
                r.pc = take_bits(32);
                r.pc[1:0] = (types[i] == cp0_pkg::AdEL && n == 1) ? 2'b10 : 2'b00;
                apply_exception(r);
                issue(r);
                expect_epc("epc_port");
                read_reg("status", cp0_pkg::STATUS_ADDR);
                read_reg("epc", cp0_pkg::EPC_ADDR);
                read_reg("cause", cp0_pkg::CAUSE_ADDR);
                read_reg("badvaddr", cp0_pkg::BADVADDR_ADDR);
                expect_irq("irq");
                r.pc = r.pc + 32'h100;           // Nested fault keeps EPC and BD
                r.bd = ~r.bd;
                apply_exception(r);
                issue(r);
                expect_epc("epc_port_nested");
                read_reg("epc_nested", cp0_pkg::EPC_ADDR);
                read_reg("cause_nested", cp0_pkg::CAUSE_ADDR);
                do_eret();
                read_reg("status_eret", cp0_pkg::STATUS_ADDR);
                expect_irq("irq_eret");
            end
        end
    endtask

    task automatic timer_test();
        logic [31:0] v;
        int          m;
        int          waited;
        test_name = "timer";
        for (int i = 0; i < 6; i++) begin
            v = take_bits(24);
            m = int'(take_bits(3));
            write_reg(cp0_pkg::COUNT_ADDR, v);
            wait_cycles(m);
            read_range("count", cp0_pkg::COUNT_ADDR, v + 32'(m / 2), v + 32'((m + 1) / 2));
        end
        v = take_bits(24);
        write_reg(cp0_pkg::COUNT_ADDR, v);
        write_reg(cp0_pkg::COMPARE_ADDR, v + 32'(TI_LEAD));
        waited = 0;
        while (irq.ti !== 1'b1 && waited < 2 * TI_LEAD + 4) begin
            wait_cycles(1);
            waited++;
        end
        if (irq.ti !== 1'b1) begin
            abort_run($sformatf("Timer interrupt not raised within %0d cycles of the Compare write",
                                2 * TI_LEAD + 4));
        end
        m_cause.ti = 1'b1;
        wait_cycles(1);                          // IP7 follows TI one edge later
        read_reg("cause_ti", cp0_pkg::CAUSE_ADDR);
        expect_irq("irq_ti");
        write_reg(cp0_pkg::COMPARE_ADDR, v + 32'h0100_0000);
        wait_cycles(2);
        read_reg("cause_ti_clear", cp0_pkg::CAUSE_ADDR);
        read_reg("compare", cp0_pkg::COMPARE_ADDR);
        expect_irq("irq_ti_clear");
    endtask

    task automatic interrupt_lines_test();
        test_name = "interrupts";
        for (int i = 0; i < 12; i++) begin
            set_ext_int(6'(take_bits(6)));
            read_reg("cause_hw", cp0_pkg::CAUSE_ADDR);
            write_reg(cp0_pkg::CAUSE_ADDR, take_bits(32));
            read_reg("cause_sw", cp0_pkg::CAUSE_ADDR);
            expect_irq("irq");
        end
        set_ext_int('0);
    endtask

    initial begin
        req = idle_req();
        ext_int = '0;
        lfsr_state = LFSR_SEED;
        word_pending = 1'b0;
        irq_pending = 1'b0;
        flag_pending = 1'b0;
        epc_pending = 1'b0;
        m_status = '0;
        m_status.bev = 1'b1;
        m_cause = '0;
        m_epc = '0;
        m_badvaddr = '0;
        m_compare = cp0_pkg::COMPARE_RESET;
        m_ext = '0;
        @(negedge reset);
        reset_values_test();
        move_access_test();
        exception_entry_test();
        timer_test();
        interrupt_lines_test();
        wait_cycles(2);
        if (uut.u_assertions.fail_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            abort_run("A bound assertion failed near the end of the run");
        end
    end

endmodule

// File: src.f
source/cp0_pkg.sv
source/cp0_access_port.sv
source/cp0_status_reg.sv
source/cp0_exception_unit.sv
source/cp0_interrupt_unit.sv
source/cp0_top.sv
dv/cp0_clock_gen.sv
dv/cp0_assertions.sv
dv/cp0_tb.sv
